// File: Makefile
# Verilator build and run of the ECC memory testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ecc_mem_tb -f src.f -o ecc_mem_sim
	./obj_dir/ecc_mem_sim | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/ecc_bank.sv
/* single-port 64-word bank storing each word with its check code;
   reads are corrected, flagged and returned one cycle after the grant */
`timescale 1ns/1ps

module ecc_bank (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clear_i,
  input  logic                                req_i,
  input  ecc_mem_pkg::tcdm_op_e               wen_i,
  input  logic [ecc_mem_pkg::ROW_W-1:0]       row_i,
  input  logic [ecc_mem_pkg::WORD_W-1:0]      data_i,
  input  logic [ecc_mem_pkg::ECC_W-1:0]       ecc_i,
  output logic                                gnt_o,
  output logic                                r_valid_o,
  output logic [ecc_mem_pkg::WORD_W-1:0]      r_data_o,
  output logic [ecc_mem_pkg::ECC_W-1:0]       r_ecc_o,
  output logic                                err_single_o,
  output logic                                err_double_o
);

  logic [ecc_mem_pkg::WORD_W-1:0] data_mem [2**ecc_mem_pkg::ROW_W];
  logic [ecc_mem_pkg::ECC_W-1:0]  ecc_mem  [2**ecc_mem_pkg::ROW_W];

  logic [ecc_mem_pkg::WORD_W-1:0] rd_data;
  logic [ecc_mem_pkg::ECC_W-1:0]  rd_ecc;
  logic [ecc_mem_pkg::ECC_W-1:0]  syn;
  logic [ecc_mem_pkg::WORD_W-1:0] corr_data;
  logic                           single_err;
  logic                           double_err;
  logic                           r_valid_q;
  logic                           err_single_q;
  logic                           err_double_q;
  logic                           do_read;

  // nothing competes for the bank
  assign gnt_o   = req_i;
  assign do_read = req_i && (wen_i == ecc_mem_pkg::OP_READ);

  assign rd_data = data_mem[row_i];
  assign rd_ecc  = ecc_mem[row_i];

  always_comb begin
    syn        = ecc_mem_pkg::ecc_syndrome(rd_data, rd_ecc);
    single_err = syn[6];
    double_err = !syn[6] && (syn[5:0] != '0);
    corr_data  = rd_data;
    // a pointer that lands on a check bit leaves the data untouched
    for (int unsigned i = 0; i < ecc_mem_pkg::WORD_W; i++) begin
      if (single_err && (ecc_mem_pkg::ecc_pos(i) == syn[5:0])) begin
        corr_data[i] = !rd_data[i];
      end
    end
  end

  // storage and read data path
  always_ff @(posedge clk_i) begin
    if (req_i && (wen_i == ecc_mem_pkg::OP_WRITE)) begin
      data_mem[row_i] <= data_i;
      ecc_mem[row_i]  <= ecc_i;
    end
    if (do_read) begin
      r_data_o <= corr_data;
      // fresh code for the corrected word
      r_ecc_o  <= ecc_mem_pkg::ecc_encode(corr_data);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q    <= 1'b0;
      err_single_q <= 1'b0;
      err_double_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q    <= 1'b0;
      err_single_q <= 1'b0;
      err_double_q <= 1'b0;
    end else begin
      r_valid_q    <= req_i;
      // writes report no error
      err_single_q <= do_read && single_err;
      err_double_q <= do_read && double_err;
    end
  end

  assign r_valid_o    = r_valid_q;
  assign err_single_o = err_single_q;
  assign err_double_o = err_double_q;

endmodule

// File: rtl/ecc_mem_pkg.sv
/* shared widths, the request opcode and the SEC-DED Hamming code helpers
   for the interleaved ECC memory; referenced by scoped names only */
package ecc_mem_pkg;

  localparam int unsigned NB_BANKS = 8;
  localparam int unsigned NB_LANES = 4;
  localparam int unsigned LANE_W   = 2;
  localparam int unsigned WORD_W   = 32;
  localparam int unsigned ECC_W    = 7;
  localparam int unsigned ROW_W    = 6;
  localparam int unsigned OFFSET_W = 3;
  localparam int unsigned ADDR_W   = 11;
  localparam int unsigned WIDE_W   = 128;

  // meaning of the tcdm wen bit
  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } tcdm_op_e;

  // codeword position (1..38) of data bit idx
  // powers of two are left free for the check bits
  function automatic logic [5:0] ecc_pos(input int unsigned idx);
    logic [5:0]  pos;
    int unsigned cnt;
    pos = '0;
    cnt = 0;
    for (int unsigned p = 3; p < 39; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (cnt == idx) begin
          pos = 6'(p);
        end
        cnt++;
      end
    end
    return pos;
  endfunction

  // check bit k covers every data bit whose position has bit k set
  // bit 6 makes the parity over data and code even
  function automatic logic [ECC_W-1:0] ecc_encode(input logic [WORD_W-1:0] data);
    logic [ECC_W-1:0] code;
    logic [5:0]       pos;
    code = '0;
    for (int unsigned i = 0; i < WORD_W; i++) begin
      pos = ecc_pos(i);
      for (int unsigned k = 0; k < 6; k++) begin
        if (pos[k]) begin
          code[k] = code[k] ^ data[i];
        end
      end
    end
    code[6] = ^{data, code[5:0]};
    return code;
  endfunction

  // bits 5:0 point at the flipped position, bit 6 is the overall parity
  // odd parity means a single error, even parity with a nonzero pointer a double
  function automatic logic [ECC_W-1:0] ecc_syndrome(input logic [WORD_W-1:0] data,
                                                    input logic [ECC_W-1:0]  ecc);
    logic [ECC_W-1:0] calc;
    logic [ECC_W-1:0] syn;
    calc      = ecc_encode(data);
    syn[5:0]  = calc[5:0] ^ ecc[5:0];
    syn[6]    = ^{data, ecc};
    return syn;
  endfunction

endpackage

// File: rtl/ecc_mem_top.sv
/* word-interleaved ECC memory: one 128-bit tcdm port routed without
   arbitration onto eight corrected single-port banks */
`timescale 1ns/1ps

module ecc_mem_top (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                clear_i,
  input  logic                                                req_i,
  output logic                                                gnt_o,
  input  ecc_mem_pkg::tcdm_op_e                               wen_i,
  input  logic [ecc_mem_pkg::ADDR_W-1:0]                      add_i,
  input  logic [ecc_mem_pkg::WIDE_W-1:0]                      data_i,
  input  logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] ecc_i,
  output logic                                                r_valid_o,
  output logic [ecc_mem_pkg::WIDE_W-1:0]                      r_data_o,
  output logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] r_ecc_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                    r_err_single_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                    r_err_double_o
);

  // router to reorder
  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_req;
  ecc_mem_pkg::tcdm_op_e [ecc_mem_pkg::NB_LANES-1:0]         lane_wen;
  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ROW_W-1:0]  lane_row;
  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_data;
  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_ecc;
  logic [ecc_mem_pkg::OFFSET_W-1:0]                          offset;
  logic                                                      granted;
  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_gnt;
  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_r_valid;
  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_r_data;
  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_r_ecc;
  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_single;
  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_double;

  // reorder to banks
  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_req;
  ecc_mem_pkg::tcdm_op_e [ecc_mem_pkg::NB_BANKS-1:0]         bank_wen;
  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ROW_W-1:0]  bank_row;
  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::WORD_W-1:0] bank_data;
  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ECC_W-1:0]  bank_ecc;
  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_gnt;
  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_r_valid;
  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::WORD_W-1:0] bank_r_data;
  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ECC_W-1:0]  bank_r_ecc;
  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_err_single;
  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_err_double;

  wide_router router_inst (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .req_i             ( req_i           ),
    .wen_i             ( wen_i           ),
    .add_i             ( add_i           ),
    .data_i            ( data_i          ),
    .ecc_i             ( ecc_i           ),
    .gnt_o             ( gnt_o           ),
    .r_valid_o         ( r_valid_o       ),
    .r_data_o          ( r_data_o        ),
    .r_ecc_o           ( r_ecc_o         ),
    .r_err_single_o    ( r_err_single_o  ),
    .r_err_double_o    ( r_err_double_o  ),
    .lane_req_o        ( lane_req        ),
    .lane_wen_o        ( lane_wen        ),
    .lane_row_o        ( lane_row        ),
    .lane_data_o       ( lane_data       ),
    .lane_ecc_o        ( lane_ecc        ),
    .offset_o          ( offset          ),
    .granted_o         ( granted         ),
    .lane_gnt_i        ( lane_gnt        ),
    .lane_r_valid_i    ( lane_r_valid    ),
    .lane_r_data_i     ( lane_r_data     ),
    .lane_r_ecc_i      ( lane_r_ecc      ),
    .lane_err_single_i ( lane_err_single ),
    .lane_err_double_i ( lane_err_double )
  );

  lane_reorder reorder_inst (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .clear_i           ( clear_i         ),
    .offset_i          ( offset          ),
    .granted_i         ( granted         ),
    .lane_req_i        ( lane_req        ),
    .lane_wen_i        ( lane_wen        ),
    .lane_row_i        ( lane_row        ),
    .lane_data_i       ( lane_data       ),
    .lane_ecc_i        ( lane_ecc        ),
    .lane_gnt_o        ( lane_gnt        ),
    .lane_r_valid_o    ( lane_r_valid    ),
    .lane_r_data_o     ( lane_r_data     ),
    .lane_r_ecc_o      ( lane_r_ecc      ),
    .lane_err_single_o ( lane_err_single ),
    .lane_err_double_o ( lane_err_double ),
    .bank_req_o        ( bank_req        ),
    .bank_wen_o        ( bank_wen        ),
    .bank_row_o        ( bank_row        ),
    .bank_data_o       ( bank_data       ),
    .bank_ecc_o        ( bank_ecc        ),
    .bank_gnt_i        ( bank_gnt        ),
    .bank_r_valid_i    ( bank_r_valid    ),
    .bank_r_data_i     ( bank_r_data     ),
    .bank_r_ecc_i      ( bank_r_ecc      ),
    .bank_err_single_i ( bank_err_single ),
    .bank_err_double_i ( bank_err_double )
  );

  for (genvar b = 0; b < ecc_mem_pkg::NB_BANKS; b++) begin : gen_bank
    ecc_bank bank_inst (
      .clk_i        ( clk_i              ),
      .rst_ni       ( rst_ni             ),
      .clear_i      ( clear_i            ),
      .req_i        ( bank_req[b]        ),
      .wen_i        ( bank_wen[b]        ),
      .row_i        ( bank_row[b]        ),
      .data_i       ( bank_data[b]       ),
      .ecc_i        ( bank_ecc[b]        ),
      .gnt_o        ( bank_gnt[b]        ),
      .r_valid_o    ( bank_r_valid[b]    ),
      .r_data_o     ( bank_r_data[b]     ),
      .r_ecc_o      ( bank_r_ecc[b]      ),
      .err_single_o ( bank_err_single[b] ),
      .err_double_o ( bank_err_double[b] )
    );
  end

endmodule

// File: rtl/lane_reorder.sv
/* rotates the four wide-port lanes onto the eight banks by bank offset and
   rotates the bank responses back into lane order one cycle later */
`timescale 1ns/1ps

module lane_reorder (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic                                                      clear_i,
  input  logic [ecc_mem_pkg::OFFSET_W-1:0]                          offset_i,
  input  logic                                                      granted_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_req_i,
  input  ecc_mem_pkg::tcdm_op_e [ecc_mem_pkg::NB_LANES-1:0]         lane_wen_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ROW_W-1:0]  lane_row_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_data_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_ecc_i,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_gnt_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_r_valid_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_r_data_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_r_ecc_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_single_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_double_o,
  output logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_req_o,
  output ecc_mem_pkg::tcdm_op_e [ecc_mem_pkg::NB_BANKS-1:0]         bank_wen_o,
  output logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ROW_W-1:0]  bank_row_o,
  output logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::WORD_W-1:0] bank_data_o,
  output logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ECC_W-1:0]  bank_ecc_o,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_gnt_i,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_r_valid_i,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::WORD_W-1:0] bank_r_data_i,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0][ecc_mem_pkg::ECC_W-1:0]  bank_r_ecc_i,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_err_single_i,
  input  logic [ecc_mem_pkg::NB_BANKS-1:0]                          bank_err_double_i
);

  // offset of the request whose response is due this cycle
  logic [ecc_mem_pkg::OFFSET_W-1:0] offset_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q <= '0;
    end else if (clear_i) begin
      offset_q <= '0;
    end else if (granted_i) begin
      offset_q <= offset_i;
    end
  end

  // bank b serves lane (b - offset) mod 8, idle when that lane does not exist
  for (genvar b = 0; b < ecc_mem_pkg::NB_BANKS; b++) begin : gen_bank_side
    logic [ecc_mem_pkg::OFFSET_W-1:0] lane_idx;
    logic [ecc_mem_pkg::LANE_W-1:0]   lane_sel;

    assign lane_idx = ecc_mem_pkg::OFFSET_W'(b) - offset_i;
    assign lane_sel = lane_idx[ecc_mem_pkg::LANE_W-1:0];

    assign bank_req_o[b]  = (lane_idx < ecc_mem_pkg::NB_LANES) && lane_req_i[lane_sel];
    assign bank_wen_o[b]  = lane_wen_i[lane_sel];
    assign bank_row_o[b]  = lane_row_i[lane_sel];
    assign bank_data_o[b] = lane_data_i[lane_sel];
    assign bank_ecc_o[b]  = lane_ecc_i[lane_sel];
  end

  for (genvar l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin : gen_lane_side
    logic [ecc_mem_pkg::OFFSET_W-1:0] req_bank;
    logic [ecc_mem_pkg::OFFSET_W-1:0] rsp_bank;

    // grant follows the live offset, responses the registered one
    assign req_bank = offset_i + ecc_mem_pkg::OFFSET_W'(l);
    assign rsp_bank = offset_q + ecc_mem_pkg::OFFSET_W'(l);

    assign lane_gnt_o[l]        = bank_gnt_i[req_bank];
    assign lane_r_valid_o[l]    = bank_r_valid_i[rsp_bank];
    assign lane_r_data_o[l]     = bank_r_data_i[rsp_bank];
    assign lane_r_ecc_o[l]      = bank_r_ecc_i[rsp_bank];
    assign lane_err_single_o[l] = bank_err_single_i[rsp_bank];
    assign lane_err_double_o[l] = bank_err_double_i[rsp_bank];
  end

endmodule

// File: rtl/wide_router.sv
/* splits a 128-bit tcdm request into four word lanes with per-lane row and
   wrap-around, and filters grant and response valid for the wide port */
`timescale 1ns/1ps

module wide_router (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  logic                                                      clear_i,
  input  logic                                                      req_i,
  input  ecc_mem_pkg::tcdm_op_e                                     wen_i,
  input  logic [ecc_mem_pkg::ADDR_W-1:0]                            add_i,
  input  logic [ecc_mem_pkg::WIDE_W-1:0]                            data_i,
  input  logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0]       ecc_i,
  output logic                                                      gnt_o,
  output logic                                                      r_valid_o,
  output logic [ecc_mem_pkg::WIDE_W-1:0]                            r_data_o,
  output logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0]       r_ecc_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          r_err_single_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          r_err_double_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_req_o,
  output ecc_mem_pkg::tcdm_op_e [ecc_mem_pkg::NB_LANES-1:0]         lane_wen_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ROW_W-1:0]  lane_row_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_data_o,
  output logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_ecc_o,
  output logic [ecc_mem_pkg::OFFSET_W-1:0]                          offset_o,
  output logic                                                      granted_o,
  input  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_gnt_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_r_valid_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::WORD_W-1:0] lane_r_data_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0][ecc_mem_pkg::ECC_W-1:0]  lane_r_ecc_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_single_i,
  input  logic [ecc_mem_pkg::NB_LANES-1:0]                          lane_err_double_i
);

  logic [ecc_mem_pkg::ROW_W-1:0] row_s;
  logic                          gnt_s;
  logic                          gnt_q;

  // byte address is {row, bank offset, byte in word}
  assign offset_o = add_i[ecc_mem_pkg::OFFSET_W+1:2];
  assign row_s    = add_i[ecc_mem_pkg::ADDR_W-1:ecc_mem_pkg::OFFSET_W+2];

  for (genvar l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin : gen_lane
    assign lane_req_o[l]  = req_i;
    assign lane_wen_o[l]  = wen_i;
    assign lane_data_o[l] = data_i[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W];
    assign lane_ecc_o[l]  = ecc_i[l*ecc_mem_pkg::ECC_W +: ecc_mem_pkg::ECC_W];

    // lanes past bank 7 land on the next row, row 63 wraps to row 0
    always_comb begin
      if (int'(offset_o) + l >= ecc_mem_pkg::NB_BANKS) begin
        lane_row_o[l] = row_s + 1'b1;
      end else begin
        lane_row_o[l] = row_s;
      end
    end

    assign r_data_o[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W] = lane_r_data_i[l];
    assign r_ecc_o[l*ecc_mem_pkg::ECC_W +: ecc_mem_pkg::ECC_W]    = lane_r_ecc_i[l];
  end

  // lane 0 stands for the whole wide request
  assign gnt_s     = req_i && lane_gnt_i[0];
  assign gnt_o     = gnt_s;
  assign granted_o = gnt_s;

  // gnt and r_valid sit in consecutive cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else if (clear_i) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= gnt_s;
    end
  end

  assign r_valid_o      = lane_r_valid_i[0] && gnt_q;
  assign r_err_single_o = lane_err_single_i;
  assign r_err_double_o = lane_err_double_i;

endmodule

// File: src.f
rtl/ecc_mem_pkg.sv
rtl/ecc_bank.sv
rtl/lane_reorder.sv
rtl/wide_router.sv
rtl/ecc_mem_top.sv
verification/ecc_mem_properties.sv
verification/ecc_mem_tb.sv

// File: verification/ecc_mem_properties.sv
/* handshake assertions for the ECC memory top level,
   attached to every ecc_mem_top instance by bind */
`timescale 1ns/1ps

module ecc_mem_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic req_i,
  input logic gnt_i,
  input logic r_valid_i
);

  // banks never stall, so the grant is the request
  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i == req_i)
    else $error("gnt_o differs from req_i");

  // a grant is answered in the very next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i) gnt_i |=> r_valid_i)
    else $error("no r_valid_o one cycle after gnt_o");

  // and no response without a grant before it
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i) !gnt_i |=> !r_valid_i)
    else $error("r_valid_o without a grant in the cycle before");

  assert property (@(posedge clk_i) !rst_ni |-> !r_valid_i)
    else $error("r_valid_o high during reset");

endmodule

bind ecc_mem_top ecc_mem_properties properties_inst (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .clear_i   ( clear_i   ),
  .req_i     ( req_i     ),
  .gnt_i     ( gnt_o     ),
  .r_valid_i ( r_valid_o )
);

// File: verification/ecc_mem_tb.sv
/* testbench for the interleaved ECC memory with LFSR stimulus on the wide port,
   a shadow memory as reference model and a negedge compare process */
`timescale 1ns/1ps

module ecc_mem_tb;

  // expected response of one granted request
  typedef struct packed {
    int                                                 issue;
    logic                                               is_read;
    logic [ecc_mem_pkg::WIDE_W-1:0]                     data;
    logic [ecc_mem_pkg::WIDE_W-1:0]                     dmask;
    logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] ecc;
    logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] emask;
    logic [ecc_mem_pkg::NB_LANES-1:0]                   sgl;
    logic [ecc_mem_pkg::NB_LANES-1:0]                   dbl;
  } exp_t;

  logic                                                clk_i = 1'b0;
  logic                                                rst_ni;
  logic                                                clear_i;
  logic                                                req_i;
  logic                                                gnt_o;
  ecc_mem_pkg::tcdm_op_e                               wen_i;
  logic [ecc_mem_pkg::ADDR_W-1:0]                      add_i;
  logic [ecc_mem_pkg::WIDE_W-1:0]                      data_i;
  logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] ecc_i;
  logic                                                r_valid_o;
  logic [ecc_mem_pkg::WIDE_W-1:0]                      r_data_o;
  logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] r_ecc_o;
  logic [ecc_mem_pkg::NB_LANES-1:0]                    r_err_single_o;
  logic [ecc_mem_pkg::NB_LANES-1:0]                    r_err_double_o;

  // shadow memory indexed by bank * 64 + row
  logic [ecc_mem_pkg::WORD_W-1:0] sh_data [ecc_mem_pkg::NB_BANKS * 2**ecc_mem_pkg::ROW_W];
  logic                           sh_sgl  [ecc_mem_pkg::NB_BANKS * 2**ecc_mem_pkg::ROW_W];
  logic                           sh_dbl  [ecc_mem_pkg::NB_BANKS * 2**ecc_mem_pkg::ROW_W];

  exp_t        exp_q [$];
  int          cyc = 0;
  int          errors = 0;
  logic [31:0] lfsr_q;

  ecc_mem_top ecc_mem_top_inst (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .req_i          ( req_i          ),
    .gnt_o          ( gnt_o          ),
    .wen_i          ( wen_i          ),
    .add_i          ( add_i          ),
    .data_i         ( data_i         ),
    .ecc_i          ( ecc_i          ),
    .r_valid_o      ( r_valid_o      ),
    .r_data_o       ( r_data_o       ),
    .r_ecc_o        ( r_ecc_o        ),
    .r_err_single_o ( r_err_single_o ),
    .r_err_double_o ( r_err_double_o )
  );

  always #50 clk_i = ~clk_i;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [ecc_mem_pkg::WIDE_W-1:0] rand_wide();
    logic [ecc_mem_pkg::WIDE_W-1:0] val;
    for (int l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin
      val[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W] = lfsr_take(ecc_mem_pkg::WORD_W);
    end
    return val;
  endfunction

  // bank and row that a lane of a wide address lands on
  function automatic int shadow_index(input logic [ecc_mem_pkg::ADDR_W-1:0] addr,
                                      input int lane);
    int pos;
    int row;
    pos = int'(addr[4:2]) + lane;
    row = int'(addr[10:5]);
    // lanes past the last bank continue in the next row modulo 64
    if (pos >= ecc_mem_pkg::NB_BANKS) begin
      row = (row + 1) % (2**ecc_mem_pkg::ROW_W);
    end
    return (pos % ecc_mem_pkg::NB_BANKS) * (2**ecc_mem_pkg::ROW_W) + row;
  endfunction

  // reference read gives corrected data with a fresh code and flags per lane
  function automatic exp_t expect_read(input logic [ecc_mem_pkg::ADDR_W-1:0] addr);
    exp_t e;
    int   idx;
    e         = '0;
    e.is_read = 1'b1;
    for (int l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin
      idx = shadow_index(addr, l);
      e.data[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W] = sh_data[idx];
      e.ecc[l*ecc_mem_pkg::ECC_W +: ecc_mem_pkg::ECC_W] = ecc_mem_pkg::ecc_encode(sh_data[idx]);
      e.sgl[l] = sh_sgl[idx];
      e.dbl[l] = sh_dbl[idx];
      // only the flag counts when a lane holds a double error
      if (!sh_dbl[idx]) begin
        e.dmask[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W] = '1;
        e.emask[l*ecc_mem_pkg::ECC_W +: ecc_mem_pkg::ECC_W]   = '1;
      end
    end
    return e;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [ecc_mem_pkg::WIDE_W-1:0] got,
                       input logic [ecc_mem_pkg::WIDE_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      fail_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // drives at the falling edge and returns at the rising edge that grants
  task automatic drive_req(input ecc_mem_pkg::tcdm_op_e op,
                           input logic [ecc_mem_pkg::ADDR_W-1:0] addr,
                           input logic [ecc_mem_pkg::WIDE_W-1:0] data,
                           input logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] ecc);
    int waits;
    req_i  = 1'b1;
    wen_i  = op;
    add_i  = addr;
    data_i = data;
    ecc_i  = ecc;
    waits  = 0;
    @(posedge clk_i);
    while (!gnt_o) begin
      waits++;
      if (waits > 16) begin
        fail_run("timeout: the DUT never granted the request");
      end
      @(posedge clk_i);
    end
  endtask

  // flips are applied to the sent data after the code is computed
  task automatic send_write(input logic [ecc_mem_pkg::ADDR_W-1:0] addr,
                            input logic [ecc_mem_pkg::WIDE_W-1:0] data,
                            input logic [ecc_mem_pkg::WIDE_W-1:0] flips);
    logic [ecc_mem_pkg::NB_LANES*ecc_mem_pkg::ECC_W-1:0] ecc;
    exp_t e;
    int   idx;
    int   nflip;
    for (int l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin
      ecc[l*ecc_mem_pkg::ECC_W +: ecc_mem_pkg::ECC_W] =
        ecc_mem_pkg::ecc_encode(data[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W]);
    end
    drive_req(ecc_mem_pkg::OP_WRITE, addr, data ^ flips, ecc);
    for (int l = 0; l < ecc_mem_pkg::NB_LANES; l++) begin
      idx          = shadow_index(addr, l);
      nflip        = $countones(flips[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W]);
      sh_data[idx] = data[l*ecc_mem_pkg::WORD_W +: ecc_mem_pkg::WORD_W];
      sh_sgl[idx]  = (nflip == 1);
      sh_dbl[idx]  = (nflip == 2);
    end
    e       = '0;
    e.issue = cyc;
    exp_q.push_back(e);
    @(negedge clk_i);
  endtask

  task automatic send_read(input logic [ecc_mem_pkg::ADDR_W-1:0] addr);
    exp_t e;
    drive_req(ecc_mem_pkg::OP_READ, addr, '0, '0);
    e       = expect_read(addr);
    e.issue = cyc;
    exp_q.push_back(e);
    @(negedge clk_i);
  endtask

  task automatic idle();
    req_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_drain();
    int waits;
    waits = 0;
    while (exp_q.size() != 0) begin
      waits++;
      if (waits > 16) begin
        fail_run("timeout: responses still outstanding at the end of the run");
      end
      @(negedge clk_i);
    end
  endtask

  // response outputs are registered and settled by the falling edge
  always @(negedge clk_i) begin : compare_rsp
    exp_t e;
    cyc = cyc + 1;
    if ((exp_q.size() != 0) && (exp_q[0].issue + 1 == cyc)) begin
      e = exp_q.pop_front();
      check("r_valid_o", 128'(r_valid_o), 128'd1);
      check("r_err_single_o", 128'(r_err_single_o), 128'(e.sgl));
      check("r_err_double_o", 128'(r_err_double_o), 128'(e.dbl));
      if (e.is_read) begin
        check("r_data_o", r_data_o & e.dmask, e.data & e.dmask);
        check("r_ecc_o", 128'(r_ecc_o & e.emask), 128'(e.ecc & e.emask));
      end
    end else begin
      check("r_valid_o", 128'(r_valid_o), 128'd0);
    end
  end

  initial begin : stimulus
    logic [ecc_mem_pkg::ROW_W-1:0]    row;
    logic [ecc_mem_pkg::OFFSET_W-1:0] off;
    logic [ecc_mem_pkg::OFFSET_W-1:0] prev_off;
    logic [1:0]                       lane;
    logic [4:0]                       bit0;
    logic [4:0]                       bit1;
    logic [ecc_mem_pkg::WIDE_W-1:0]   flips;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    req_i   = 1'b0;
    wen_i   = ecc_mem_pkg::OP_READ;
    add_i   = '0;
    data_i  = '0;
    ecc_i   = '0;
    lfsr_q  = 32'hec18ba7f;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // fill every row through aligned offsets 0 and 4 and read it all back
    for (int r = 0; r < 2**ecc_mem_pkg::ROW_W; r++) begin
      send_write({6'(r), 3'd0, 2'd0}, rand_wide(), '0);
      send_write({6'(r), 3'd4, 2'd0}, rand_wide(), '0);
    end
    for (int r = 0; r < 2**ecc_mem_pkg::ROW_W; r++) begin
      send_read({6'(r), 3'd0, 2'd0});
      send_read({6'(r), 3'd4, 2'd0});
    end
    idle();

    // wrapped writes at offsets 5..7 starting in the top row
    for (int i = 0; i < 24; i++) begin
      row = (i == 0) ? 6'd63 : 6'(lfsr_take(6));
      off = 3'(5 + lfsr_take(2) % 3);
      send_write({row, off, 2'd0}, rand_wide(), '0);
      idle();
      // aligned views of both rows touched by the wrap
      send_read({row, 3'd4, 2'd0});
      send_read({row + 6'd1, 3'd0, 2'd0});
      send_read({row, off, 2'd0});
      idle();
    end

    // back-to-back reads where each offset differs from the one before
    prev_off = '0;
    for (int i = 0; i < 32; i++) begin
      off = 3'(lfsr_take(3));
      if (off == prev_off) begin
        off = off + 3'd1;
      end
      prev_off = off;
      send_read({6'(lfsr_take(6)), off, 2'd0});
    end
    idle();

    // one flipped data bit in one lane
    for (int i = 0; i < 8; i++) begin
      row          = 6'(lfsr_take(6));
      off          = 3'(lfsr_take(3));
      lane         = 2'(lfsr_take(2));
      bit0         = 5'(lfsr_take(5));
      flips        = '0;
      flips[{lane, bit0}] = 1'b1;
      send_write({row, off, 2'd0}, rand_wide(), flips);
      send_read({row, off, 2'd0});
      idle();
    end

    // two distinct flipped bits in one lane
    for (int i = 0; i < 8; i++) begin
      row          = 6'(lfsr_take(6));
      off          = 3'(lfsr_take(3));
      lane         = 2'(lfsr_take(2));
      bit0         = 5'(lfsr_take(5));
      bit1         = bit0 + 5'(1 + lfsr_take(4));
      flips        = '0;
      flips[{lane, bit0}] = 1'b1;
      flips[{lane, bit1}] = 1'b1;
      send_write({row, off, 2'd0}, rand_wide(), flips);
      send_read({row, off, 2'd0});
      idle();
    end

    // clear in an idle cycle keeps the stored words
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_read({6'(lfsr_take(6)), 3'(lfsr_take(3)), 2'd0});
    end
    idle();
    wait_drain();

    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
